/* test/rs_stim.txt */
# C name  op0: dest cls s1 r1 s2 r2 mask  op1: same  cdb0 cdb1  br_task br_mask  hold
# dest or cdb tag 0 means none; cls 0 alu 1 mult 2 mem; br_task 0 none 1 squash 2 clear
# hold bits stop unit credit returns: 1 alu, 2 mult, 4 mem
# E cls dest wait_tag lists an expected issue; wait_tag is 0 when no broadcast is needed
C ready      10 0 1 1 2 1 0    11 0 1 1 3 1 0    0 0    0 0  0
C ready      12 2 1 1 2 1 0    13 1 4 1 5 1 0    0 0    0 0  0
C wakeup     20 0 40 0 2 1 0   21 2 41 0 42 0 0  0 0    0 0  0
C wakeup     0 0 0 0 0 0 0     0 0 0 0 0 0 0     0 0    0 0  0
C wakeup     0 0 0 0 0 0 0     0 0 0 0 0 0 0     40 41  0 0  0
C wakeup     0 0 0 0 0 0 0     0 0 0 0 0 0 0     42 0   0 0  0
C mult_hold  30 1 6 1 7 1 0    31 1 6 1 7 1 0    0 0    0 0  2
C mult_hold  32 1 6 1 7 1 0    33 1 6 1 7 1 0    0 0    0 0  2
C mult_hold  0 0 0 0 0 0 0     0 0 0 0 0 0 0     0 0    0 0  2
C mult_hold  0 0 0 0 0 0 0     0 0 0 0 0 0 0     0 0    0 0  2
C mult_hold  0 0 0 0 0 0 0     0 0 0 0 0 0 0     0 0    0 0  2
C mult_hold  0 0 0 0 0 0 0     0 0 0 0 0 0 0     0 0    0 0  0
C squash     50 0 60 0 2 1 1   51 2 60 0 3 1 1   0 0    0 0  0
C squash     52 0 61 0 2 1 2   54 1 61 0 3 1 2   0 0    0 0  0
C squash     53 0 1 1 2 1 1    0 0 0 0 0 0 0     0 0    1 1  0
C clear      0 0 0 0 0 0 0     0 0 0 0 0 0 0     0 0    2 2  0
C clear      0 0 0 0 0 0 0     0 0 0 0 0 0 0     60 61  0 0  0
C clear      0 0 0 0 0 0 0     0 0 0 0 0 0 0     0 0    0 0  0
E 0 10 0
E 0 11 0
E 2 12 0
E 1 13 0
E 0 20 40
E 2 21 42
E 1 30 0
E 1 31 0
E 1 32 0
E 1 33 0
E 0 52 61
E 1 54 61

/* verilog.f */
source/rs_pkg.sv
source/free_slot_picker.sv
source/issue_picker.sv
source/rs_entry_array.sv
source/rs_control.sv
source/reservation_station.sv
test/rs_tb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module rs_tb -o rs_sim

out=$(./obj_dir/rs_sim)
echo "$out"

if grep -q "^PASS: all tests$" <<< "$out"; then
    exit 0
fi
exit 1

/* test/rs_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_tb import rs_pkg::*;;

    localparam int DEPTH    = rs_depth_c;
    localparam int WIDTH    = dispatch_width_c;
    localparam int NUM_ALU  = num_alu_c;
    localparam int NUM_MULT = num_mult_c;
    localparam int NUM_MEM  = num_mem_c;
    localparam int CNT_W    = $clog2(DEPTH + 1);
    localparam int MAX_LINES = 64;

    logic                  clock;
    logic                  reset;
    rs_op_t [WIDTH-1:0]    dispatch_ops;
    logic   [CNT_W-1:0]    dispatch_credit;
    cdb_t   [WIDTH-1:0]    cdb;
    br_update_t            br_update;
    logic   [NUM_ALU-1:0]  alu_credit_return;
    logic   [NUM_MULT-1:0] mult_credit_return;
    logic   [NUM_MEM-1:0]  mem_credit_return;
    issue_t [NUM_ALU-1:0]  alu_issue;
    issue_t [NUM_MULT-1:0] mult_issue;
    issue_t [NUM_MEM-1:0]  mem_issue;

    // stimulus table with one row per cycle line of the data file
    int    fields[MAX_LINES][19];
    string names[MAX_LINES];
    int    n_lines;
    bit    loaded;

    int    exp_cnt[3][64];
    int    wait_of[3][64];
    int    seen[3][64];
    int    exp_src1[64];
    int    exp_src2[64];
    int    cdb_at[64];
    int    cycle;
    int    exp_total;
    int    seen_total;

    // outstanding unit work with one delay per issued op
    int    delay[3][16];
    int    npend[3];
    int    model_cred[3];
    int    dcred;
    int    cur_hold;
    string cur_name;

    int    val_errs;
    int    other_errs;
    logic [31:0] rng;

    reservation_station #(
        .DEPTH    (DEPTH),
        .WIDTH    (WIDTH),
        .NUM_ALU  (NUM_ALU),
        .NUM_MULT (NUM_MULT),
        .NUM_MEM  (NUM_MEM)
    ) i_reservation_station (
        .clock              (clock),
        .reset              (reset),
        .dispatch_ops       (dispatch_ops),
        .dispatch_credit    (dispatch_credit),
        .cdb                (cdb),
        .br_update          (br_update),
        .alu_credit_return  (alu_credit_return),
        .mult_credit_return (mult_credit_return),
        .mem_credit_return  (mem_credit_return),
        .alu_issue          (alu_issue),
        .mult_issue         (mult_issue),
        .mem_issue          (mem_issue)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] r;

        r = x ^ (x << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    task automatic check_value(input string test, input int expected, input int actual);
        if (expected != actual) begin
            val_errs++;
            $display("ERR %s expected %0d actual %0d", test, expected, actual);
        end
    endtask

    function automatic rs_op_t make_op(input int d, input int cls, input int a, input int ar,
                                       input int b, input int br, input int m);
        rs_op_t op;

        op.valid     = (d != 0);
        op.dest      = tag_t'(d);
        op.fu_class  = fu_class_e'(cls);
        op.src1.tag  = tag_t'(a);
        op.src1.ready = (ar != 0);
        op.src2.tag  = tag_t'(b);
        op.src2.ready = (br != 0);
        op.br_mask   = br_mask_t'(m);
        return op;
    endfunction

    task automatic record_issue(input int c, input issue_t iss);
        int d;
        int w;

        d = int'(iss.dest);
        w = wait_of[c][d];
        seen[c][d]++;
        seen_total++;
        if (model_cred[c] <= 0) begin
            other_errs++;
            $display("%s: class %0d issued op %0d with no unit credit left", cur_name, c, d);
        end
        model_cred[c]--;
        check_value({cur_name, " issue count"}, exp_cnt[c][d], seen[c][d]);
        check_value({cur_name, " src1 tag"}, exp_src1[d], int'(iss.src1));
        check_value({cur_name, " src2 tag"}, exp_src2[d], int'(iss.src2));
        if (w != 0) begin
            // a tag driven in cycle n wakes at the next edge and is seen issued at n + 3
            check_value({cur_name, " issued before wakeup"}, 1,
                        int'(cdb_at[w] != 0 && cycle >= cdb_at[w] + 3));
        end
        rng = xorshift(rng);
        delay[c][npend[c]] = 1 + int'(rng % 4);
        npend[c]++;
    endtask

    // ages the pending work of a class and hands back finished credits
    function automatic int take_returns(input int c, input int units);
        int n;
        int k;

        n = 0;
        if (((cur_hold >> c) & 1) == 0) begin
            k = 0;
            while (k < npend[c]) begin
                delay[c][k]--;
                if (delay[c][k] <= 0 && n < units) begin
                    n++;
                    delay[c][k] = delay[c][npend[c] - 1];
                    npend[c]--;
                end else begin
                    k++;
                end
            end
        end
        model_cred[c] += n;
        return n;
    endfunction

    task automatic observe();
        int n;

        cycle++;
        dcred += int'(dispatch_credit);
        for (int u = 0; u < NUM_ALU; u++) begin
            if (alu_issue[u].valid) record_issue(0, alu_issue[u]);
        end
        for (int u = 0; u < NUM_MULT; u++) begin
            if (mult_issue[u].valid) record_issue(1, mult_issue[u]);
        end
        for (int u = 0; u < NUM_MEM; u++) begin
            if (mem_issue[u].valid) record_issue(2, mem_issue[u]);
        end
        n = take_returns(0, NUM_ALU);
        alu_credit_return <= NUM_ALU'((1 << n) - 1);
        n = take_returns(1, NUM_MULT);
        mult_credit_return <= NUM_MULT'((1 << n) - 1);
        n = take_returns(2, NUM_MEM);
        mem_credit_return <= NUM_MEM'((1 << n) - 1);
    endtask

    task automatic drive_idle();
        dispatch_ops <= '0;
        cdb          <= '0;
        br_update    <= '0;
    endtask

    task automatic drive_line(input int i);
        rs_op_t [WIDTH-1:0] ops;
        cdb_t   [WIDTH-1:0] bus;

        ops[0] = make_op(fields[i][0], fields[i][1], fields[i][2], fields[i][3],
                         fields[i][4], fields[i][5], fields[i][6]);
        ops[1] = make_op(fields[i][7], fields[i][8], fields[i][9], fields[i][10],
                         fields[i][11], fields[i][12], fields[i][13]);
        if (fields[i][0] != 0) begin
            exp_src1[fields[i][0]] = fields[i][2];
            exp_src2[fields[i][0]] = fields[i][4];
        end
        if (fields[i][7] != 0) begin
            exp_src1[fields[i][7]] = fields[i][9];
            exp_src2[fields[i][7]] = fields[i][11];
        end
        for (int k = 0; k < WIDTH; k++) begin
            bus[k].valid = (fields[i][14 + k] != 0);
            bus[k].tag   = tag_t'(fields[i][14 + k]);
            if (bus[k].valid) cdb_at[fields[i][14 + k]] = cycle;
        end
        dispatch_ops      <= ops;
        cdb               <= bus;
        br_update.br_task <= br_task_e'(fields[i][16]);
        br_update.mask    <= br_mask_t'(fields[i][17]);
        cur_hold = fields[i][18];
        cur_name = names[i];
    endtask

    task automatic load_stim();
        int    fd;
        int    c;
        int    t;
        int    w;
        string line;
        string nm;
        int    v[19];

        fd = $fopen("test/rs_stim.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the stimulus file test/rs_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.substr(0, 0) == "#") continue;
                if (line.substr(0, 0) == "E") begin
                    void'($sscanf(line, "E %d %d %d", c, t, w));
                    exp_cnt[c][t] = 1;
                    wait_of[c][t] = w;
                    exp_total++;
                end else if (line.substr(0, 0) == "C" && n_lines < MAX_LINES) begin
                    void'($sscanf(line,
                        "C %s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        nm, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                        v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]));
                    names[n_lines] = nm;
                    for (int k = 0; k < 19; k++) fields[n_lines][k] = v[k];
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int idx;
        int need;

        reset              = 1'b1;
        dispatch_ops       = '0;
        cdb                = '0;
        br_update          = '0;
        alu_credit_return  = '0;
        mult_credit_return = '0;
        mem_credit_return  = '0;
        rng        = 32'hf9df;
        model_cred = '{NUM_ALU, NUM_MULT, NUM_MEM};
        dcred      = DEPTH;
        cycle      = 0;
        cur_hold   = 0;
        cur_name   = "reset";
        load_stim();
        loaded = 1'b1;

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        idx = 0;
        while (idx < n_lines) begin
            @(posedge clock);
            observe();
            need = int'(fields[idx][0] != 0) + int'(fields[idx][7] != 0);
            // the front end holds the whole line until it has credits for it
            if (need <= dcred) begin
                drive_line(idx);
                dcred -= need;
                idx++;
            end else begin
                drive_idle();
            end
        end

        cur_name = "drain";
        cur_hold = 0;
        while (seen_total < exp_total || npend[0] + npend[1] + npend[2] != 0) begin
            @(posedge clock);
            observe();
            drive_idle();
        end
        repeat (3) begin
            @(posedge clock);
            observe();
            drive_idle();
        end

        for (int c = 0; c < 3; c++) begin
            for (int t = 0; t < 64; t++) begin
                check_value($sformatf("final class %0d tag %0d", c, t), exp_cnt[c][t], seen[c][t]);
            end
        end
        check_value("final dispatch credits", DEPTH, dcred);

        $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat ((n_lines + 1) * 40) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", (n_lines + 1) * 40);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* source/reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_station import rs_pkg::*; #(
    parameter int DEPTH    = rs_depth_c,
    parameter int WIDTH    = dispatch_width_c,
    parameter int NUM_ALU  = num_alu_c,
    parameter int NUM_MULT = num_mult_c,
    parameter int NUM_MEM  = num_mem_c,
    localparam int CNT_W   = $clog2(DEPTH + 1),
    localparam int ALU_CW  = $clog2(NUM_ALU + 1),
    localparam int MULT_CW = $clog2(NUM_MULT + 1),
    localparam int MEM_CW  = $clog2(NUM_MEM + 1)
) (
    input  logic                  clock,
    input  logic                  reset,
    input  rs_op_t [WIDTH-1:0]    dispatch_ops,
    output logic   [CNT_W-1:0]    dispatch_credit,
    input  cdb_t   [WIDTH-1:0]    cdb,
    input  br_update_t            br_update,
    input  logic   [NUM_ALU-1:0]  alu_credit_return,
    input  logic   [NUM_MULT-1:0] mult_credit_return,
    input  logic   [NUM_MEM-1:0]  mem_credit_return,
    output issue_t [NUM_ALU-1:0]  alu_issue,
    output issue_t [NUM_MULT-1:0] mult_issue,
    output issue_t [NUM_MEM-1:0]  mem_issue
);

    rs_op_t [DEPTH-1:0]              entries;
    logic   [DEPTH-1:0]              free;
    logic   [WIDTH-1:0][DEPTH-1:0]   dispatch_grants;
    logic   [DEPTH-1:0]              alu_ready;
    logic   [DEPTH-1:0]              mult_ready;
    logic   [DEPTH-1:0]              mem_ready;
    logic   [ALU_CW-1:0]             alu_credits;
    logic   [MULT_CW-1:0]            mult_credits;
    logic   [MEM_CW-1:0]             mem_credits;
    logic   [NUM_ALU-1:0][DEPTH-1:0] alu_grants;
    logic   [NUM_MULT-1:0][DEPTH-1:0] mult_grants;
    logic   [NUM_MEM-1:0][DEPTH-1:0] mem_grants;
    logic   [DEPTH-1:0]              alu_picked;
    logic   [DEPTH-1:0]              mult_picked;
    logic   [DEPTH-1:0]              mem_picked;
    logic   [DEPTH-1:0]              picked;
    logic   [CNT_W-1:0]              squashed_count;

    assign picked = alu_picked | mult_picked | mem_picked;

    free_slot_picker #(.WIDTH(WIDTH), .DEPTH(DEPTH)) i_free_slot_picker (
        .free   (free),
        .grants (dispatch_grants)
    );

    issue_picker #(.DEPTH(DEPTH), .NUM_FU(NUM_ALU)) i_alu_picker (
        .ready_req   (alu_ready),
        .credits     (alu_credits),
        .unit_grants (alu_grants),
        .picked      (alu_picked)
    );

    issue_picker #(.DEPTH(DEPTH), .NUM_FU(NUM_MULT)) i_mult_picker (
        .ready_req   (mult_ready),
        .credits     (mult_credits),
        .unit_grants (mult_grants),
        .picked      (mult_picked)
    );

    issue_picker #(.DEPTH(DEPTH), .NUM_FU(NUM_MEM)) i_mem_picker (
        .ready_req   (mem_ready),
        .credits     (mem_credits),
        .unit_grants (mem_grants),
        .picked      (mem_picked)
    );

    rs_entry_array #(.DEPTH(DEPTH), .WIDTH(WIDTH)) i_rs_entry_array (
        .clock           (clock),
        .reset           (reset),
        .dispatch_ops    (dispatch_ops),
        .dispatch_grants (dispatch_grants),
        .cdb             (cdb),
        .br_update       (br_update),
        .picked          (picked),
        .entries         (entries),
        .free            (free),
        .alu_ready       (alu_ready),
        .mult_ready      (mult_ready),
        .mem_ready       (mem_ready),
        .squashed_count  (squashed_count)
    );

    rs_control #(
        .DEPTH    (DEPTH),
        .NUM_ALU  (NUM_ALU),
        .NUM_MULT (NUM_MULT),
        .NUM_MEM  (NUM_MEM)
    ) i_rs_control (
        .clock              (clock),
        .reset              (reset),
        .entries            (entries),
        .alu_grants         (alu_grants),
        .mult_grants        (mult_grants),
        .mem_grants         (mem_grants),
        .squashed_count     (squashed_count),
        .alu_credit_return  (alu_credit_return),
        .mult_credit_return (mult_credit_return),
        .mem_credit_return  (mem_credit_return),
        .alu_credits        (alu_credits),
        .mult_credits       (mult_credits),
        .mem_credits        (mem_credits),
        .alu_issue          (alu_issue),
        .mult_issue         (mult_issue),
        .mem_issue          (mem_issue),
        .dispatch_credit    (dispatch_credit)
    );

endmodule

`default_nettype wire

/* source/rs_control.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_control import rs_pkg::*; #(
    parameter int DEPTH    = rs_depth_c,
    parameter int NUM_ALU  = num_alu_c,
    parameter int NUM_MULT = num_mult_c,
    parameter int NUM_MEM  = num_mem_c,
    localparam int CNT_W   = $clog2(DEPTH + 1),
    localparam int ALU_CW  = $clog2(NUM_ALU + 1),
    localparam int MULT_CW = $clog2(NUM_MULT + 1),
    localparam int MEM_CW  = $clog2(NUM_MEM + 1)
) (
    input  logic                            clock,
    input  logic                            reset,
    input  rs_op_t [DEPTH-1:0]              entries,
    input  logic   [NUM_ALU-1:0][DEPTH-1:0] alu_grants,
    input  logic   [NUM_MULT-1:0][DEPTH-1:0] mult_grants,
    input  logic   [NUM_MEM-1:0][DEPTH-1:0] mem_grants,
    input  logic   [CNT_W-1:0]              squashed_count,
    input  logic   [NUM_ALU-1:0]            alu_credit_return,
    input  logic   [NUM_MULT-1:0]           mult_credit_return,
    input  logic   [NUM_MEM-1:0]            mem_credit_return,
    output logic   [ALU_CW-1:0]             alu_credits,
    output logic   [MULT_CW-1:0]            mult_credits,
    output logic   [MEM_CW-1:0]             mem_credits,
    output issue_t [NUM_ALU-1:0]            alu_issue,
    output issue_t [NUM_MULT-1:0]           mult_issue,
    output issue_t [NUM_MEM-1:0]            mem_issue,
    output logic   [CNT_W-1:0]              dispatch_credit
);

    issue_t [NUM_ALU-1:0]  alu_issue_d;
    issue_t [NUM_MULT-1:0] mult_issue_d;
    issue_t [NUM_MEM-1:0]  mem_issue_d;
    logic   [ALU_CW-1:0]   alu_credits_d;
    logic   [MULT_CW-1:0]  mult_credits_d;
    logic   [MEM_CW-1:0]   mem_credits_d;
    logic   [CNT_W-1:0]    dispatch_credit_d;

    // grants are one-hot, so an OR over the grant works as the mux
    function automatic issue_t pick_entry(input rs_op_t [DEPTH-1:0] ents,
                                          input logic [DEPTH-1:0] grant);
        issue_t r;

        r = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (grant[i]) begin
                r.valid = 1'b1;
                r.dest  = ents[i].dest;
                r.src1  = ents[i].src1.tag;
                r.src2  = ents[i].src2.tag;
            end
        end
        return r;
    endfunction

    always_comb begin
        int alu_used;
        int mult_used;
        int mem_used;
        int alu_back;
        int mult_back;
        int mem_back;

        alu_used = 0;
        alu_back = 0;
        for (int u = 0; u < NUM_ALU; u++) begin
            alu_issue_d[u] = pick_entry(entries, alu_grants[u]);
            alu_used += int'(alu_issue_d[u].valid);
            alu_back += int'(alu_credit_return[u]);
        end
        mult_used = 0;
        mult_back = 0;
        for (int u = 0; u < NUM_MULT; u++) begin
            mult_issue_d[u] = pick_entry(entries, mult_grants[u]);
            mult_used += int'(mult_issue_d[u].valid);
            mult_back += int'(mult_credit_return[u]);
        end
        mem_used = 0;
        mem_back = 0;
        for (int u = 0; u < NUM_MEM; u++) begin
            mem_issue_d[u] = pick_entry(entries, mem_grants[u]);
            mem_used += int'(mem_issue_d[u].valid);
            mem_back += int'(mem_credit_return[u]);
        end

        alu_credits_d  = ALU_CW'(int'(alu_credits) - alu_used + alu_back);
        mult_credits_d = MULT_CW'(int'(mult_credits) - mult_used + mult_back);
        mem_credits_d  = MEM_CW'(int'(mem_credits) - mem_used + mem_back);
        // every issued or squashed entry frees one dispatch slot
        dispatch_credit_d = CNT_W'(alu_used + mult_used + mem_used + int'(squashed_count));
    end

    always_ff @(posedge clock) begin
        alu_issue  <= alu_issue_d;
        mult_issue <= mult_issue_d;
        mem_issue  <= mem_issue_d;
        if (reset) begin
            for (int u = 0; u < NUM_ALU; u++) alu_issue[u].valid <= 1'b0;
            for (int u = 0; u < NUM_MULT; u++) mult_issue[u].valid <= 1'b0;
            for (int u = 0; u < NUM_MEM; u++) mem_issue[u].valid <= 1'b0;
            alu_credits     <= ALU_CW'(NUM_ALU);
            mult_credits    <= MULT_CW'(NUM_MULT);
            mem_credits     <= MEM_CW'(NUM_MEM);
            dispatch_credit <= '0;
        end else begin
            alu_credits     <= alu_credits_d;
            mult_credits    <= mult_credits_d;
            mem_credits     <= mem_credits_d;
            dispatch_credit <= dispatch_credit_d;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        alu_credits <= ALU_CW'(NUM_ALU) && mult_credits <= MULT_CW'(NUM_MULT)
        && mem_credits <= MEM_CW'(NUM_MEM))
        else $error("rs_control: class credits above unit count");

    // a unit only hands back a credit it was given
    assert property (@(posedge clock) disable iff (reset)
        (alu_credits != ALU_CW'(NUM_ALU) || alu_credit_return == '0)
        && (mult_credits != MULT_CW'(NUM_MULT) || mult_credit_return == '0)
        && (mem_credits != MEM_CW'(NUM_MEM) || mem_credit_return == '0))
        else $error("rs_control: credit returned to a full counter");

endmodule

`default_nettype wire

/* source/rs_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_entry_array import rs_pkg::*; #(
    parameter int DEPTH   = rs_depth_c,
    parameter int WIDTH   = dispatch_width_c,
    localparam int CNT_W  = $clog2(DEPTH + 1)
) (
    input  logic                          clock,
    input  logic                          reset,
    input  rs_op_t [WIDTH-1:0]            dispatch_ops,
    input  logic   [WIDTH-1:0][DEPTH-1:0] dispatch_grants,
    input  cdb_t   [WIDTH-1:0]            cdb,
    input  br_update_t                    br_update,
    input  logic   [DEPTH-1:0]            picked,
    output rs_op_t [DEPTH-1:0]            entries,
    output logic   [DEPTH-1:0]            free,
    output logic   [DEPTH-1:0]            alu_ready,
    output logic   [DEPTH-1:0]            mult_ready,
    output logic   [DEPTH-1:0]            mem_ready,
    output logic   [CNT_W-1:0]            squashed_count
);

    rs_op_t [DEPTH-1:0] entries_d;
    logic   [DEPTH-1:0] squash_hit;

    function automatic src_t wake_src(input src_t src, input cdb_t [WIDTH-1:0] bus);
        src_t r;

        r = src;
        for (int c = 0; c < WIDTH; c++) begin
            if (bus[c].valid && bus[c].tag == src.tag) begin
                r.ready = 1'b1;
            end
        end
        return r;
    endfunction

    function automatic logic on_squashed_path(input br_mask_t mask, input br_update_t upd);
        return (upd.br_task == br_squash) && ((mask & upd.mask) != '0);
    endfunction

    always_comb begin
        logic both_ready;

        for (int i = 0; i < DEPTH; i++) begin
            squash_hit[i] = entries[i].valid
                && on_squashed_path(entries[i].br_mask, br_update);
            both_ready = entries[i].valid && entries[i].src1.ready
                && entries[i].src2.ready && !squash_hit[i];
            free[i]       = !entries[i].valid;
            alu_ready[i]  = both_ready && entries[i].fu_class == fu_alu;
            mult_ready[i] = both_ready && entries[i].fu_class == fu_mult;
            mem_ready[i]  = both_ready && entries[i].fu_class == fu_mem;
        end
    end

    always_comb begin
        rs_op_t op;
        int     n_sq;

        entries_d = entries;
        n_sq = 0;
        for (int i = 0; i < DEPTH; i++) begin
            entries_d[i].src1 = wake_src(entries[i].src1, cdb);
            entries_d[i].src2 = wake_src(entries[i].src2, cdb);
            if (br_update.br_task == br_clear) begin
                entries_d[i].br_mask = entries[i].br_mask & ~br_update.mask;
            end
            if (squash_hit[i]) begin
                entries_d[i].valid = 1'b0;
                n_sq++;
            end
            if (picked[i]) begin
                entries_d[i].valid = 1'b0;
            end
        end

        // incoming ops see the same wakeup and branch update as stored ones
        for (int k = 0; k < WIDTH; k++) begin
            op = dispatch_ops[k];
            op.src1 = wake_src(op.src1, cdb);
            op.src2 = wake_src(op.src2, cdb);
            if (br_update.br_task == br_clear) begin
                op.br_mask = op.br_mask & ~br_update.mask;
            end
            if (op.valid && on_squashed_path(op.br_mask, br_update)) begin
                // dies before it lands but its credit still goes back
                n_sq++;
            end else if (op.valid) begin
                for (int j = 0; j < DEPTH; j++) begin
                    if (dispatch_grants[k][j]) begin
                        entries_d[j] = op;
                    end
                end
            end
        end
        squashed_count = CNT_W'(n_sq);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= entries_d;
        end
    end

    // every valid dispatch op lands in a free slot
    for (genvar k = 0; k < WIDTH; k++) begin : g_dispatch_chk
        assert property (@(posedge clock) disable iff (reset)
            dispatch_ops[k].valid |-> dispatch_grants[k] != '0)
            else $error("rs_entry_array: dispatch op %0d has no free slot", k);
    end

endmodule

`default_nettype wire

/* source/issue_picker.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_picker import rs_pkg::*; #(
    parameter int DEPTH    = rs_depth_c,
    parameter int NUM_FU   = num_alu_c,
    localparam int CRED_W  = $clog2(NUM_FU + 1)
) (
    input  logic [DEPTH-1:0]             ready_req,
    input  logic [CRED_W-1:0]            credits,
    output logic [NUM_FU-1:0][DEPTH-1:0] unit_grants,
    output logic [DEPTH-1:0]             picked
);

    always_comb begin
        int limit;
        int n;
        int n_picked;

        // no more picks than units, and no more than free credits
        limit = (int'(credits) < NUM_FU) ? int'(credits) : NUM_FU;
        n = 0;
        unit_grants = '0;
        picked = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ready_req[i] && n < limit) begin
                unit_grants[n][i] = 1'b1;
                picked[i] = 1'b1;
                n++;
            end
        end

        n_picked = 0;
        for (int i = 0; i < DEPTH; i++) begin
            if (picked[i]) begin
                n_picked++;
            end
        end
        assert ((picked & ~ready_req) == '0 && n_picked <= int'(credits))
            else $error("issue_picker: pick outside ready set or beyond credits");
    end

endmodule

`default_nettype wire

/* source/free_slot_picker.sv */
`timescale 1ns/1ps
`default_nettype none

module free_slot_picker import rs_pkg::*; #(
    parameter int WIDTH = dispatch_width_c,
    parameter int DEPTH = rs_depth_c
) (
    input  logic [DEPTH-1:0]            free,
    output logic [WIDTH-1:0][DEPTH-1:0] grants
);

    always_comb begin
        logic [DEPTH-1:0] avail;

        avail  = free;
        grants = '0;
        for (int k = 0; k < WIDTH; k++) begin
            // lowest remaining free slot goes to dispatch port k
            for (int i = 0; i < DEPTH; i++) begin
                if (avail[i] && grants[k] == '0) begin
                    grants[k][i] = 1'b1;
                end
            end
            avail = avail & ~grants[k];
        end

        for (int k = 0; k < WIDTH; k++) begin
            assert ($onehot0(grants[k]))
                else $error("free_slot_picker: grant %0d is not one-hot", k);
            assert ((grants[k] & ~free) == '0)
                else $error("free_slot_picker: grant %0d hits a busy slot", k);
            for (int j = k + 1; j < WIDTH; j++) begin
                assert ((grants[k] & grants[j]) == '0)
                    else $error("free_slot_picker: grants %0d and %0d overlap", k, j);
            end
        end
    end

endmodule

`default_nettype wire

/* source/rs_pkg.sv */
`default_nettype none

package rs_pkg;

    // default sizes, the top level passes its own values down
    localparam int rs_depth_c       = 8;
    localparam int dispatch_width_c = 2;
    localparam int num_alu_c        = 2;
    localparam int num_mult_c       = 1;
    localparam int num_mem_c        = 1;

    typedef logic [5:0] tag_t;
    typedef logic [3:0] br_mask_t;

    typedef enum logic [1:0] {
        fu_alu  = 2'd0,
        fu_mult = 2'd1,
        fu_mem  = 2'd2
    } fu_class_e;

    // source operand, tag only since values live in the register file
    typedef struct packed {
        tag_t tag;
        logic ready;
    } src_t;

    typedef struct packed {
        logic      valid;
        tag_t      dest;
        fu_class_e fu_class;
        src_t      src1;
        src_t      src2;
        br_mask_t  br_mask;
    } rs_op_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_t;

    typedef enum logic [1:0] {
        br_none   = 2'd0,
        br_squash = 2'd1,
        br_clear  = 2'd2
    } br_task_e;

    // mask is one-hot, it names the resolved branch
    typedef struct packed {
        br_task_e br_task;
        br_mask_t mask;
    } br_update_t;

    // what a functional unit receives
    typedef struct packed {
        logic valid;
        tag_t dest;
        tag_t src1;
        tag_t src2;
    } issue_t;

endpackage

`default_nettype wire
